/* tomasulo_core.f */
verilog/lc3b_types.sv
verilog/issue_control.sv
verilog/reg_status_file.sv
verilog/reorder_buffer.sv
verilog/alu_station.sv
verilog/cdb_arbiter.sv
verilog/tomasulo_core.sv
tests/tomasulo_core_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build with Verilator and run; exit status is nonzero on any failure
cd "$(dirname "$0")" &&
	verilator --binary --assert -j 0 -f tomasulo_core.f \
		--top-module tomasulo_core_tb -o tomasulo_core_sim &&
	./obj_dir/tomasulo_core_sim ||
	{ echo "Simulation build or run failed"; exit 1; }

/* tests/tomasulo_core_tb.sv */
module tomasulo_core_tb;
timeunit 1ns;
timeprecision 100ps;

localparam int tag_width = 3;
localparam int issue_limit = 200;	// Cycles one word may sit in stall
localparam int drain_limit = 1000;

logic clk;
logic reset;
lc3b_types::lc3b_word instr;
logic instr_is_new;
lc3b_types::lc3b_word curr_pc;
logic stall;
logic commit_valid;
lc3b_types::lc3b_reg commit_reg;
lc3b_types::lc3b_word commit_value;

lc3b_types::lc3b_word model [8];	// Architectural state in issue order
logic [18:0] expect_q [$];	// {reg, value} of each issued instruction
logic head_valid;
lc3b_types::lc3b_reg head_reg;
lc3b_types::lc3b_word head_value;
logic started;
int stall_seen;
int burst_stalls;
logic [31:0] rng_state;
lc3b_types::lc3b_word pc;

tomasulo_core #(.tag_width(tag_width)) dut0
(
	.clk, .reset, .instr, .instr_is_new, .curr_pc,
	.stall, .commit_valid, .commit_reg, .commit_value
);

always #2 clk = ~clk;

task automatic print_failure(input string why);
	$display("%s", why);
	$display("SOME TESTS FAILED");
endtask

task automatic report_mismatch(input string name, input logic [15:0] expected,
	input logic [15:0] actual);
	print_failure($sformatf("CHECK FAILED at time %0d ns: %s expected %h got %h",
		$time, name, expected, actual));
endtask

function automatic logic [31:0] lcg_step(input logic [31:0] s);
	return s * 32'd1664525 + 32'd1013904223;
endfunction

task automatic draw(output logic [15:0] r);
	rng_state = lcg_step(rng_state);
	r = rng_state[31:16];	// Upper bits have the longer period
endtask

function automatic lc3b_types::lc3b_word sext5(input logic [4:0] v);
	return 16'(signed'(v));
endfunction

function automatic lc3b_types::lc3b_word sext9(input logic [8:0] v);
	return 16'(signed'(v));
endfunction

// Present one word until it issues, then record what it must commit
task automatic send(input lc3b_types::lc3b_word word, input lc3b_types::lc3b_reg dr,
	input lc3b_types::lc3b_word value);
	int waited;
	waited = 0;
	started = 1'b1;
	instr = word;
	curr_pc = pc;
	instr_is_new = 1'b1;
	#1;
	while (stall)
	begin
		stall_seen++;
		if (waited == issue_limit)
		begin
			print_failure("Timeout: an instruction was held by stall and never issued");
			$fatal(1);
		end
		waited++;
		@(negedge clk);
		#1;
	end
	@(negedge clk);	// Issued at the edge just passed
	model[dr] = value;
	expect_q.push_back({dr, value});
	instr_is_new = 1'b0;
	pc = pc + 16'd2;
endtask

task automatic add_imm(input lc3b_types::lc3b_reg dr, input lc3b_types::lc3b_reg sr,
	input logic [4:0] imm);
	send({lc3b_types::op_add, dr, sr, 1'b1, imm}, dr, model[sr] + sext5(imm));
endtask

task automatic and_imm(input lc3b_types::lc3b_reg dr, input lc3b_types::lc3b_reg sr,
	input logic [4:0] imm);
	send({lc3b_types::op_and, dr, sr, 1'b1, imm}, dr, model[sr] & sext5(imm));
endtask

task automatic add_reg(input lc3b_types::lc3b_reg dr, input lc3b_types::lc3b_reg s1,
	input lc3b_types::lc3b_reg s2);
	send({lc3b_types::op_add, dr, s1, 1'b0, 2'b00, s2}, dr, model[s1] + model[s2]);
endtask

task automatic and_reg(input lc3b_types::lc3b_reg dr, input lc3b_types::lc3b_reg s1,
	input lc3b_types::lc3b_reg s2);
	send({lc3b_types::op_and, dr, s1, 1'b0, 2'b00, s2}, dr, model[s1] & model[s2]);
endtask

task automatic not_reg(input lc3b_types::lc3b_reg dr, input lc3b_types::lc3b_reg sr);
	send({lc3b_types::op_not, dr, sr, 6'b111111}, dr, ~model[sr]);
endtask

task automatic lea(input lc3b_types::lc3b_reg dr, input logic [8:0] off);
	send({lc3b_types::op_lea, dr, off}, dr, pc + (sext9(off) << 1));	// Byte address
endtask

task automatic random_op();
	logic [15:0] r;
	draw(r);
	case (r[2:0])
		3'd0, 3'd1: add_imm(r[5:3], r[8:6], r[13:9]);
		3'd2: and_imm(r[5:3], r[8:6], r[13:9]);
		3'd3: add_reg(r[5:3], r[8:6], r[11:9]);
		3'd4: and_reg(r[5:3], r[8:6], r[11:9]);
		3'd5: not_reg(r[5:3], r[8:6]);
		default: lea(r[5:3], r[14:6]);
	endcase
endtask

task automatic wait_drain();
	int waited;
	waited = 0;
	while (expect_q.size() != 0)
	begin
		if (waited == drain_limit)
		begin
			print_failure("Timeout: issued instructions never committed");
			$fatal(1);
		end
		waited++;
		@(negedge clk);
	end
endtask

// Retire the checked commit and expose the next expected one
always @(negedge clk)
begin
	#1;
	if (!reset && commit_valid && expect_q.size() != 0)
		void'(expect_q.pop_front());
	head_valid = (expect_q.size() != 0);
	if (head_valid)
		{head_reg, head_value} = expect_q[0];
end

idle_stall: assert property (@(negedge clk) disable iff (reset) !started |-> !stall)
	else
	begin
		report_mismatch("stall", 16'h0, 16'(stall));
		$fatal(1);
	end

idle_commit: assert property (@(negedge clk) disable iff (reset) !started |-> !commit_valid)
	else
	begin
		report_mismatch("commit_valid", 16'h0, 16'(commit_valid));
		$fatal(1);
	end

commit_expected: assert property (@(negedge clk) disable iff (reset) commit_valid |-> head_valid)
	else
	begin
		print_failure("A commit arrived with no instruction outstanding");
		$fatal(1);
	end

commit_reg_ok: assert property (@(negedge clk) disable iff (reset)
	(commit_valid && head_valid) |-> (commit_reg == head_reg))
	else
	begin
		report_mismatch("commit_reg", 16'(head_reg), 16'(commit_reg));
		$fatal(1);
	end

commit_value_ok: assert property (@(negedge clk) disable iff (reset)
	(commit_valid && head_valid) |-> (commit_value == head_value))
	else
	begin
		report_mismatch("commit_value", head_value, commit_value);
		$fatal(1);
	end

initial
begin
	logic [15:0] r;
	lc3b_types::lc3b_reg prev;
	lc3b_types::lc3b_reg dr;
	int burst_start;
	clk = 1'b0;
	reset = 1'b1;
	instr = '0;
	instr_is_new = 1'b0;
	curr_pc = '0;
	started = 1'b0;
	stall_seen = 0;
	burst_stalls = 0;
	head_valid = 1'b0;
	head_reg = '0;
	head_value = '0;
	rng_state = 32'ha0f2_049d;
	pc = 16'h3000;
	for (int k = 0; k < 8; k++)
		model[k] = '0;
	repeat (8) @(posedge clk);
	@(negedge clk);
	reset = 1'b0;
	repeat (6) @(negedge clk);	// Quiet window for the idle checks

	// Immediate ADD and AND chains
	prev = 3'd0;
	for (int k = 0; k < 16; k++)
	begin
		draw(r);
		dr = r[2:0];
		if (r[3] || r[4])
			add_imm(dr, prev, r[9:5]);
		else
			and_imm(dr, prev, r[9:5]);
		prev = dr;
	end

	// LEA loads every register, then the offset extremes
	for (int k = 0; k < 8; k++)
	begin
		draw(r);
		pc = {r[15:1], 1'b0};
		draw(r);
		lea(3'(k), r[8:0]);
	end
	lea(3'd0, 9'h100);
	lea(3'd7, 9'h1ff);
	lea(3'd6, 9'h0ff);

	// Register forms on fresh results
	add_reg(3'd1, 3'd2, 3'd3);
	and_reg(3'd4, 3'd1, 3'd2);
	not_reg(3'd5, 3'd4);
	add_reg(3'd6, 3'd5, 3'd1);
	add_reg(3'd6, 3'd6, 3'd6);
	and_reg(3'd7, 3'd6, 3'd5);
	not_reg(3'd1, 3'd7);
	add_reg(3'd2, 3'd1, 3'd7);
	add_reg(3'd3, 3'd0, 3'd2);
	and_reg(3'd0, 3'd3, 3'd3);
	wait_drain();

	// Serial burst fills the stations and the ROB
	burst_start = stall_seen;
	prev = 3'd1;
	for (int k = 0; k < 48; k++)
	begin
		draw(r);
		dr = r[2:0];
		case (r[4:3])
			2'd0: add_imm(dr, prev, r[9:5]);
			2'd1: add_reg(dr, prev, r[12:10]);
			2'd2: and_reg(dr, prev, r[12:10]);
			default: not_reg(dr, prev);
		endcase
		prev = dr;
	end
	burst_stalls = stall_seen - burst_start;
	burst_stalled: assert (burst_stalls != 0)
		else
		begin
			print_failure("Stall never rose during the instruction burst");
			$fatal(1);
		end
	wait_drain();

	// Mixed program, then read back each register
	for (int k = 0; k < 64; k++)
		random_op();
	for (int k = 0; k < 8; k++)
		add_imm(3'(k), 3'(k), 5'd0);
	wait_drain();

	$display("ALL TESTS PASSED");
	$finish;
end

endmodule : tomasulo_core_tb

/* verilog/tomasulo_core.sv */
module tomasulo_core #(parameter tag_width = 3)
(
	input logic clk,
	input logic reset,
	input lc3b_types::lc3b_word instr,
	input logic instr_is_new,
	input lc3b_types::lc3b_word curr_pc,

	output logic stall,
	output logic commit_valid,
	output lc3b_types::lc3b_reg commit_reg,
	output lc3b_types::lc3b_word commit_value
);

logic cdb_valid;
logic [tag_width-1:0] cdb_tag;
lc3b_types::lc3b_word cdb_data;

logic [2:0] station_load, station_busy, station_done, grant;
lc3b_types::alu_fn res_fn;
lc3b_types::lc3b_word res_Vj, res_Vk;
logic [tag_width-1:0] res_Qj, res_Qk, res_dest;
logic res_j_ready, res_k_ready;
lc3b_types::lc3b_word result0, result1, result2;
logic [tag_width-1:0] tag0, tag1, tag2;

logic rob_write_enable, rob_value_ready, rob_full;
lc3b_types::lc3b_reg rob_dest;
lc3b_types::lc3b_word rob_value_in;
logic [tag_width-1:0] rob_addr, commit_tag;
lc3b_types::lc3b_word rob_sr1_value, rob_sr2_value;
logic rob_sr1_valid, rob_sr2_valid;

lc3b_types::lc3b_reg sr1, sr2, reg_dest;
logic ld_reg_busy_dest;
logic [tag_width-1:0] reg_rob_entry;
lc3b_types::lc3b_word sr1_value, sr2_value;
logic sr1_busy, sr2_busy;
logic [tag_width-1:0] sr1_tag, sr2_tag;

issue_control #(.tag_width(tag_width)) issue0
(
	.clk, .instr, .instr_is_new, .curr_pc,
	.cdb_valid, .cdb_tag, .cdb_data,
	.station_busy, .rob_full, .rob_addr,
	.rob_sr1_value, .rob_sr2_value, .rob_sr1_valid, .rob_sr2_valid,
	.sr1_value, .sr1_busy, .sr1_tag, .sr2_value, .sr2_busy, .sr2_tag,
	.stall, .station_load, .res_fn, .res_Vj, .res_Vk, .res_Qj, .res_Qk,
	.res_j_ready, .res_k_ready, .res_dest,
	.rob_write_enable, .rob_dest, .rob_value_in, .rob_value_ready,
	.sr1, .sr2, .reg_dest, .ld_reg_busy_dest, .reg_rob_entry
);

reg_status_file #(.tag_width(tag_width)) regs0
(
	.clk, .reset, .sr1, .sr2, .reg_dest, .ld_reg_busy_dest, .reg_rob_entry,
	.commit_valid, .commit_reg, .commit_value, .commit_tag,
	.sr1_value, .sr1_busy, .sr1_tag, .sr2_value, .sr2_busy, .sr2_tag
);

// Source tags from the register file index the ROB directly
reorder_buffer #(.tag_width(tag_width)) rob0
(
	.clk, .reset, .rob_write_enable, .rob_dest, .rob_value_in, .rob_value_ready,
	.cdb_valid, .cdb_tag, .cdb_data,
	.rob_sr1_read_addr(sr1_tag), .rob_sr2_read_addr(sr2_tag),
	.rob_full, .rob_addr, .rob_sr1_value, .rob_sr1_valid, .rob_sr2_value, .rob_sr2_valid,
	.commit_valid, .commit_reg, .commit_value, .commit_tag
);

alu_station #(.tag_width(tag_width)) station0
(
	.clk, .reset, .load(station_load[0]), .res_fn, .res_Vj, .res_Vk, .res_Qj, .res_Qk,
	.res_j_ready, .res_k_ready, .res_dest, .cdb_valid, .cdb_tag, .cdb_data,
	.grant(grant[0]), .busy(station_busy[0]), .done(station_done[0]),
	.result(result0), .result_tag(tag0)
);

alu_station #(.tag_width(tag_width)) station1
(
	.clk, .reset, .load(station_load[1]), .res_fn, .res_Vj, .res_Vk, .res_Qj, .res_Qk,
	.res_j_ready, .res_k_ready, .res_dest, .cdb_valid, .cdb_tag, .cdb_data,
	.grant(grant[1]), .busy(station_busy[1]), .done(station_done[1]),
	.result(result1), .result_tag(tag1)
);

alu_station #(.tag_width(tag_width)) station2
(
	.clk, .reset, .load(station_load[2]), .res_fn, .res_Vj, .res_Vk, .res_Qj, .res_Qk,
	.res_j_ready, .res_k_ready, .res_dest, .cdb_valid, .cdb_tag, .cdb_data,
	.grant(grant[2]), .busy(station_busy[2]), .done(station_done[2]),
	.result(result2), .result_tag(tag2)
);

cdb_arbiter #(.tag_width(tag_width)) arbiter0
(
	.clk, .reset, .done(station_done),
	.result0, .result1, .result2, .tag0, .tag1, .tag2,
	.grant, .cdb_valid, .cdb_tag, .cdb_data
);

endmodule : tomasulo_core

/* verilog/cdb_arbiter.sv */
module cdb_arbiter #(parameter tag_width = 3)
(
	input logic clk,
	input logic reset,
	input logic [2:0] done,
	input lc3b_types::lc3b_word result0,
	input lc3b_types::lc3b_word result1,
	input lc3b_types::lc3b_word result2,
	input logic [tag_width-1:0] tag0,
	input logic [tag_width-1:0] tag1,
	input logic [tag_width-1:0] tag2,

	output logic [2:0] grant,
	output logic cdb_valid,
	output logic [tag_width-1:0] cdb_tag,
	output lc3b_types::lc3b_word cdb_data
);

// Station 0 has highest priority
assign grant[0] = done[0];
assign grant[1] = done[1] && !done[0];
assign grant[2] = done[2] && !done[1] && !done[0];

always_ff @(posedge clk)
begin
	if (reset)
		cdb_valid <= 1'b0;
	else
		cdb_valid <= |done;
end

always_ff @(posedge clk)
begin
	if (grant[0])
	begin
		cdb_tag <= tag0;
		cdb_data <= result0;
	end
	else if (grant[1])
	begin
		cdb_tag <= tag1;
		cdb_data <= result1;
	end
	else if (grant[2])
	begin
		cdb_tag <= tag2;
		cdb_data <= result2;
	end
end

endmodule : cdb_arbiter

/* verilog/alu_station.sv */
module alu_station #(parameter tag_width = 3)
(
	input logic clk,
	input logic reset,
	input logic load,
	input lc3b_types::alu_fn res_fn,
	input lc3b_types::lc3b_word res_Vj,
	input lc3b_types::lc3b_word res_Vk,
	input logic [tag_width-1:0] res_Qj,
	input logic [tag_width-1:0] res_Qk,
	input logic res_j_ready,
	input logic res_k_ready,
	input logic [tag_width-1:0] res_dest,
	input logic cdb_valid,
	input logic [tag_width-1:0] cdb_tag,
	input lc3b_types::lc3b_word cdb_data,
	input logic grant,

	output logic busy,
	output logic done,
	output lc3b_types::lc3b_word result,
	output logic [tag_width-1:0] result_tag
);

lc3b_types::alu_fn fn;
lc3b_types::lc3b_word vj, vk, alu_out;
logic [tag_width-1:0] qj, qk;
logic j_ready, k_ready;
logic snoop_j, snoop_k, start;

assign snoop_j = busy && !j_ready && cdb_valid && (cdb_tag == qj);
assign snoop_k = busy && !k_ready && cdb_valid && (cdb_tag == qk);
assign start = busy && j_ready && k_ready && !done;

always_comb
begin
	case (fn)
		lc3b_types::fn_and: alu_out = vj & vk;
		lc3b_types::fn_not: alu_out = ~vj;
		default: alu_out = vj + vk;
	endcase
end

always_ff @(posedge clk)
begin
	if (reset)
	begin
		busy <= 1'b0;
		done <= 1'b0;
		j_ready <= 1'b0;
		k_ready <= 1'b0;
	end
	else if (load)
	begin
		busy <= 1'b1;
		done <= 1'b0;
		j_ready <= res_j_ready;
		k_ready <= res_k_ready;
	end
	else if (grant)
	begin
		busy <= 1'b0;	// Result leaves on the bus
		done <= 1'b0;
	end
	else
	begin
		if (snoop_j)
			j_ready <= 1'b1;
		if (snoop_k)
			k_ready <= 1'b1;
		if (start)
			done <= 1'b1;
	end
end

always_ff @(posedge clk)
begin
	if (load)
	begin
		fn <= res_fn;
		vj <= res_Vj;
		vk <= res_Vk;
		qj <= res_Qj;
		qk <= res_Qk;
		result_tag <= res_dest;
	end
	else
	begin
		if (snoop_j)
			vj <= cdb_data;
		if (snoop_k)
			vk <= cdb_data;
		if (start)
			result <= alu_out;
	end
end

endmodule : alu_station

/* verilog/reorder_buffer.sv */
module reorder_buffer #(parameter tag_width = 3)
(
	input logic clk,
	input logic reset,
	input logic rob_write_enable,
	input lc3b_types::lc3b_reg rob_dest,
	input lc3b_types::lc3b_word rob_value_in,
	input logic rob_value_ready,
	input logic cdb_valid,
	input logic [tag_width-1:0] cdb_tag,
	input lc3b_types::lc3b_word cdb_data,
	input logic [tag_width-1:0] rob_sr1_read_addr,
	input logic [tag_width-1:0] rob_sr2_read_addr,

	output logic rob_full,
	output logic [tag_width-1:0] rob_addr,
	output lc3b_types::lc3b_word rob_sr1_value,
	output logic rob_sr1_valid,
	output lc3b_types::lc3b_word rob_sr2_value,
	output logic rob_sr2_valid,
	output logic commit_valid,
	output lc3b_types::lc3b_reg commit_reg,
	output lc3b_types::lc3b_word commit_value,
	output logic [tag_width-1:0] commit_tag
);

localparam int depth = 1 << tag_width;

lc3b_types::lc3b_reg entry_reg [depth];
lc3b_types::lc3b_word entry_value [depth];
logic [depth-1:0] entry_ready;
logic [tag_width-1:0] head;
logic [tag_width-1:0] tail;
logic [tag_width:0] count;
logic do_commit;

assign rob_full = (count == (tag_width+1)'(depth));
assign rob_addr = tail;
assign do_commit = (count != '0) && entry_ready[head];

// Operand lookup by tag
assign rob_sr1_value = entry_value[rob_sr1_read_addr];
assign rob_sr1_valid = entry_ready[rob_sr1_read_addr];
assign rob_sr2_value = entry_value[rob_sr2_read_addr];
assign rob_sr2_valid = entry_ready[rob_sr2_read_addr];

always_ff @(posedge clk)
begin
	if (reset)
	begin
		head <= '0;
		tail <= '0;
		count <= '0;
		entry_ready <= '0;
		commit_valid <= 1'b0;
	end
	else
	begin
		if (cdb_valid)
			entry_ready[cdb_tag] <= 1'b1;
		if (rob_write_enable)
		begin
			entry_ready[tail] <= rob_value_ready;	// LEA arrives ready
			tail <= tail + 1'b1;
		end
		if (do_commit)
			head <= head + 1'b1;
		count <= count + (tag_width+1)'(rob_write_enable) - (tag_width+1)'(do_commit);
		commit_valid <= do_commit;
	end
end

always_ff @(posedge clk)
begin
	if (cdb_valid)
		entry_value[cdb_tag] <= cdb_data;
	if (rob_write_enable)
	begin
		entry_reg[tail] <= rob_dest;
		entry_value[tail] <= rob_value_in;
	end
	if (do_commit)
	begin
		commit_reg <= entry_reg[head];
		commit_value <= entry_value[head];
		commit_tag <= head;
	end
end

endmodule : reorder_buffer

/* verilog/reg_status_file.sv */
module reg_status_file #(parameter tag_width = 3)
(
	input logic clk,
	input logic reset,
	input lc3b_types::lc3b_reg sr1,
	input lc3b_types::lc3b_reg sr2,
	input lc3b_types::lc3b_reg reg_dest,
	input logic ld_reg_busy_dest,
	input logic [tag_width-1:0] reg_rob_entry,
	input logic commit_valid,
	input lc3b_types::lc3b_reg commit_reg,
	input lc3b_types::lc3b_word commit_value,
	input logic [tag_width-1:0] commit_tag,

	output lc3b_types::lc3b_word sr1_value,
	output logic sr1_busy,
	output logic [tag_width-1:0] sr1_tag,
	output lc3b_types::lc3b_word sr2_value,
	output logic sr2_busy,
	output logic [tag_width-1:0] sr2_tag
);

lc3b_types::lc3b_word value [8];
logic [7:0] busy;
logic [tag_width-1:0] tag [8];

always_ff @(posedge clk)
begin
	if (reset)
	begin
		for (int i = 0; i < 8; i++)
		begin
			value[i] <= '0;
			tag[i] <= '0;
		end
		busy <= '0;
	end
	else
	begin
		if (commit_valid)
		begin
			value[commit_reg] <= commit_value;
			if (tag[commit_reg] == commit_tag)	// Newer writer still pending otherwise
				busy[commit_reg] <= 1'b0;
		end
		// Issue mark comes last and wins
		if (ld_reg_busy_dest)
		begin
			busy[reg_dest] <= 1'b1;
			tag[reg_dest] <= reg_rob_entry;
		end
	end
end

assign sr1_value = value[sr1];
assign sr1_busy = busy[sr1];
assign sr1_tag = tag[sr1];
assign sr2_value = value[sr2];
assign sr2_busy = busy[sr2];
assign sr2_tag = tag[sr2];

endmodule : reg_status_file

/* verilog/issue_control.sv */
module issue_control #(parameter tag_width = 3)
(
	input logic clk,
	input lc3b_types::lc3b_word instr,
	input logic instr_is_new,
	input lc3b_types::lc3b_word curr_pc,
	input logic cdb_valid,
	input logic [tag_width-1:0] cdb_tag,
	input lc3b_types::lc3b_word cdb_data,
	input logic [2:0] station_busy,
	input logic rob_full,
	input logic [tag_width-1:0] rob_addr,
	input lc3b_types::lc3b_word rob_sr1_value,
	input lc3b_types::lc3b_word rob_sr2_value,
	input logic rob_sr1_valid,
	input logic rob_sr2_valid,
	input lc3b_types::lc3b_word sr1_value,
	input logic sr1_busy,
	input logic [tag_width-1:0] sr1_tag,
	input lc3b_types::lc3b_word sr2_value,
	input logic sr2_busy,
	input logic [tag_width-1:0] sr2_tag,

	output logic stall,
	output logic [2:0] station_load,
	output lc3b_types::alu_fn res_fn,
	output lc3b_types::lc3b_word res_Vj,
	output lc3b_types::lc3b_word res_Vk,
	output logic [tag_width-1:0] res_Qj,
	output logic [tag_width-1:0] res_Qk,
	output logic res_j_ready,
	output logic res_k_ready,
	output logic [tag_width-1:0] res_dest,
	output logic rob_write_enable,
	output lc3b_types::lc3b_reg rob_dest,
	output lc3b_types::lc3b_word rob_value_in,
	output logic rob_value_ready,
	output lc3b_types::lc3b_reg sr1,
	output lc3b_types::lc3b_reg sr2,
	output lc3b_types::lc3b_reg reg_dest,
	output logic ld_reg_busy_dest,
	output logic [tag_width-1:0] reg_rob_entry
);

lc3b_types::lc3b_instr ir;
lc3b_types::lc3b_opcode opcode;
lc3b_types::lc3b_word sext5;
logic [8:0] offset9;
lc3b_types::lc3b_word lea_value;
logic is_alu;

assign ir = instr;
assign opcode = ir.reg_form.opcode;
assign sr1 = ir.reg_form.sr1;
assign sr2 = ir.reg_form.sr2;
assign offset9 = ir.imm_form[8:0];
assign sext5 = {{11{ir.imm_form.imm5[4]}}, ir.imm_form.imm5};
assign lea_value = curr_pc + {{6{offset9[8]}}, offset9, 1'b0};	// Word offset to byte address

assign is_alu = (opcode == lc3b_types::op_add) || (opcode == lc3b_types::op_and) ||
	(opcode == lc3b_types::op_not);

// Every dispatched result goes to the ROB tail
assign res_dest = rob_addr;
assign rob_dest = ir.reg_form.dest;
assign reg_dest = ir.reg_form.dest;
assign reg_rob_entry = rob_addr;
assign rob_value_in = lea_value;	// Only meaningful when ready at issue

assign stall = instr_is_new && (rob_full || (is_alu && (&station_busy)));

always_comb
begin
	station_load = 3'b000;
	res_fn = lc3b_types::fn_add;
	res_Vj = '0;
	res_Vk = '0;
	res_Qj = '0;
	res_Qk = '0;
	res_j_ready = 1'b0;
	res_k_ready = 1'b0;
	rob_write_enable = 1'b0;
	rob_value_ready = 1'b0;
	ld_reg_busy_dest = 1'b0;

	if (instr_is_new && !stall)
	begin
		if (is_alu)
		begin
			// First free station
			if (!station_busy[0])
				station_load = 3'b001;
			else if (!station_busy[1])
				station_load = 3'b010;
			else
				station_load = 3'b100;

			case (opcode)
				lc3b_types::op_and: res_fn = lc3b_types::fn_and;
				lc3b_types::op_not: res_fn = lc3b_types::fn_not;
				default: res_fn = lc3b_types::fn_add;
			endcase

			// J operand
			if (!sr1_busy)
			begin
				res_Vj = sr1_value;
				res_j_ready = 1'b1;
			end
			else if (cdb_valid && cdb_tag == sr1_tag)	// Broadcast this cycle
			begin
				res_Vj = cdb_data;
				res_j_ready = 1'b1;
			end
			else if (rob_sr1_valid)
			begin
				res_Vj = rob_sr1_value;
				res_j_ready = 1'b1;
			end
			else
				res_Qj = sr1_tag;	// Wait on the bus

			// K operand
			if (opcode == lc3b_types::op_not)
				res_k_ready = 1'b1;	// Unused by NOT
			else if (ir.reg_form.imm)
			begin
				res_Vk = sext5;
				res_k_ready = 1'b1;
			end
			else if (!sr2_busy)
			begin
				res_Vk = sr2_value;
				res_k_ready = 1'b1;
			end
			else if (cdb_valid && cdb_tag == sr2_tag)
			begin
				res_Vk = cdb_data;
				res_k_ready = 1'b1;
			end
			else if (rob_sr2_valid)
			begin
				res_Vk = rob_sr2_value;
				res_k_ready = 1'b1;
			end
			else
				res_Qk = sr2_tag;

			rob_write_enable = 1'b1;
			ld_reg_busy_dest = 1'b1;
		end
		else if (opcode == lc3b_types::op_lea)
		begin
			// Result known now so no station is needed
			rob_write_enable = 1'b1;
			rob_value_ready = 1'b1;
			ld_reg_busy_dest = 1'b1;
		end
	end
end

endmodule : issue_control

/* verilog/lc3b_types.sv */
package lc3b_types;

typedef logic [15:0] lc3b_word;
typedef logic [2:0] lc3b_reg;

// LC-3b opcode field encodings
typedef enum logic [3:0] {
	op_br  = 4'b0000,
	op_add = 4'b0001,
	op_and = 4'b0101,
	op_ldr = 4'b0110,
	op_str = 4'b0111,
	op_not = 4'b1001,
	op_jmp = 4'b1100,
	op_shf = 4'b1101,
	op_lea = 4'b1110
} lc3b_opcode;

// Operation handed from issue to the ALU stations
typedef enum logic [1:0] {
	fn_add = 2'b00,
	fn_and = 2'b01,
	fn_not = 2'b10
} alu_fn;

// One instruction word, two decodings
typedef union packed {
	struct packed {
		lc3b_opcode opcode;
		lc3b_reg dest;
		lc3b_reg sr1;
		logic imm;         // Bit 5 selects imm5 over sr2
		logic [1:0] unused;
		lc3b_reg sr2;
	} reg_form;
	struct packed {
		lc3b_opcode opcode;
		lc3b_reg dest;
		lc3b_reg sr1;
		logic imm;
		logic [4:0] imm5;  // Low nine bits also hold the LEA offset9
	} imm_form;
} lc3b_instr;

endpackage : lc3b_types
